// File: logic/mac_settings.svh
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// operand width of each multiplier input
`define MAC_OPND_W 4

// full unsigned product, twice the operand width
`define MAC_PROD_W 8

// accumulator width
`define MAC_ACC_W 16

`endif

// File: logic/mac_pkg.sv
`default_nettype none

`include "mac_settings.svh"

package mac_pkg;

    typedef enum logic [1:0] {
        OP_HOLD = 2'd0,  // accumulator unchanged
        OP_LOAD = 2'd1,  // accumulator takes the product
        OP_ADD  = 2'd2,  // acc + product
        OP_SUB  = 2'd3   // acc - product
    } mac_op_e;

    typedef struct packed {
        mac_op_e op;
        logic    sat_en;  // clamp instead of wrap
    } mac_cfg_t;

    // stage-1 register, each item keeps its own cfg
    typedef struct packed {
        logic                   valid;
        logic [`MAC_PROD_W-1:0] product;
        mac_cfg_t               cfg;
    } mac_stage_t;

endpackage

`default_nettype wire

// File: logic/ks_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ks_adder #(
    parameter int WIDTH = 4
) (
    input  wire [WIDTH-1:0] a,
    input  wire [WIDTH-1:0] b,
    input  wire             cin,
    output wire [WIDTH-1:0] sum,
    output wire             cout
);
    // position 0 of the prefix tree carries cin, bit i of a/b sits at i+1
    localparam int LEVELS = $clog2(WIDTH + 1);

    wire [WIDTH:0] g_lvl [0:LEVELS];
    wire [WIDTH:0] p_lvl [0:LEVELS-1];  // last level needs no propagate

    assign g_lvl[0] = {a & b, cin};
    assign p_lvl[0] = {a ^ b, 1'b0};

    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
        localparam int D = 1 << lvl;  // span doubles every level

        for (genvar k = 0; k <= WIDTH; k++) begin : g_pos
            if (k < D) begin : g_pass
                assign g_lvl[lvl+1][k] = g_lvl[lvl][k];
            end else begin : g_cell
                // gray and black cells share the generate term
                assign g_lvl[lvl+1][k] = g_lvl[lvl][k] | (p_lvl[lvl][k] & g_lvl[lvl][k-D]);
            end

            if (lvl < LEVELS - 1) begin : g_prop
                if (k < D) begin : g_p_pass
                    assign p_lvl[lvl+1][k] = p_lvl[lvl][k];
                end else if (k < 2 * D) begin : g_p_gray
                    assign p_lvl[lvl+1][k] = 1'b0;  // group reaches cin, fully resolved
                end else begin : g_p_black
                    assign p_lvl[lvl+1][k] = p_lvl[lvl][k] & p_lvl[lvl][k-D];
                end
            end
        end
    end

    // carry into bit i is the group generate ending at position i
    assign sum  = p_lvl[0][WIDTH:1] ^ g_lvl[LEVELS][WIDTH-1:0];
    assign cout = g_lvl[LEVELS][WIDTH];

endmodule

`default_nettype wire

// File: logic/array_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module array_multiplier (
    input  wire [`MAC_OPND_W-1:0] a,
    input  wire [`MAC_OPND_W-1:0] b,
    output wire [`MAC_PROD_W-1:0] product
);
    localparam int W = `MAC_OPND_W;

    wire [W-1:0] pp      [0:W-1];  // pp[i] is b gated by a[i]
    wire [W-1:0] row_in  [1:W-1];
    wire [W-1:0] row_sum [1:W-1];
    wire         row_co  [1:W-1];

    for (genvar i = 0; i < W; i++) begin : g_pp
        assign pp[i] = a[i] ? b : '0;
    end

    assign product[0] = pp[0][0];  // lsb needs no adder

    // each row adds the next partial product to the shifted running sum
    for (genvar r = 1; r < W; r++) begin : g_row
        if (r == 1) begin : g_first
            assign row_in[r] = {1'b0, pp[0][W-1:1]};
        end else begin : g_chain
            assign row_in[r] = {row_co[r-1], row_sum[r-1][W-1:1]};  // carry joins next row
        end

        ks_adder #(
            .WIDTH (W)
        ) u_row_add (
            .a    (row_in[r]),
            .b    (pp[r]),
            .cin  (1'b0),
            .sum  (row_sum[r]),
            .cout (row_co[r])
        );

        if (r < W - 1) begin : g_low_bit
            assign product[r] = row_sum[r][0];  // settled bit drops out
        end
    end

    // last row supplies the upper half
    assign product[`MAC_PROD_W-1:W-1] = {row_co[W-1], row_sum[W-1]};

endmodule

`default_nettype wire

// File: logic/mac_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mac_ctrl_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cfg_we,
    input  wire mac_pkg::mac_op_e cfg_op,
    input  wire                  cfg_sat,
    output mac_pkg::mac_cfg_t    cfg
);
    import mac_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.op     <= OP_ADD;  // default is plain accumulate
            cfg.sat_en <= 1'b0;
        end else if (cfg_we) begin
            cfg.op     <= cfg_op;
            cfg.sat_en <= cfg_sat;
        end
    end

    // all four codes are opcodes so only X or Z is illegal
    a_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(cfg)
    ) else $error("cfg.op illegal or unknown");

endmodule

`default_nettype wire

// File: logic/mac_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module mac_datapath (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    input  wire [`MAC_OPND_W-1:0]  a,
    input  wire [`MAC_OPND_W-1:0]  b,
    input  wire                    acc_clr,
    input  wire mac_pkg::mac_cfg_t cfg,
    output logic                   out_valid,
    output logic [`MAC_ACC_W-1:0]  acc
);
    import mac_pkg::*;

    localparam int PAD_W = `MAC_ACC_W - `MAC_PROD_W;

    wire  [`MAC_PROD_W-1:0] product;
    mac_stage_t             stage_q;
    logic [`MAC_ACC_W-1:0]  prod_ext;
    logic                   is_sub;
    logic [`MAC_ACC_W-1:0]  add_b;
    wire  [`MAC_ACC_W-1:0]  add_sum;
    wire                    add_cout;
    logic [`MAC_ACC_W-1:0]  acc_nxt;

    array_multiplier u_mult (
        .a       (a),
        .b       (b),
        .product (product)
    );

    // stage 1: product and the cfg current at sampling
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_q.valid <= 1'b0;
        end else begin
            stage_q.valid <= in_valid;
        end
        if (in_valid) begin
            stage_q.product <= product;
            stage_q.cfg     <= cfg;
        end
    end

    // stage 2: subtract as acc + ~prod + 1
    assign prod_ext = {{PAD_W{1'b0}}, stage_q.product};
    assign is_sub   = (stage_q.cfg.op == OP_SUB);
    assign add_b    = is_sub ? ~prod_ext : prod_ext;

    ks_adder #(
        .WIDTH (`MAC_ACC_W)
    ) u_acc_add (
        .a    (acc),
        .b    (add_b),
        .cin  (is_sub),
        .sum  (add_sum),
        .cout (add_cout)
    );

    always_comb begin
        acc_nxt = acc;
        case (stage_q.cfg.op)
            OP_HOLD: acc_nxt = acc;
            OP_LOAD: acc_nxt = prod_ext;
            OP_ADD:  acc_nxt = (stage_q.cfg.sat_en && add_cout) ? '1 : add_sum;   // overflow
            OP_SUB:  acc_nxt = (stage_q.cfg.sat_en && !add_cout) ? '0 : add_sum;  // borrow
            default: acc_nxt = acc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            acc       <= '0;
        end else begin
            out_valid <= stage_q.valid;
            if (acc_clr) begin
                acc <= '0;  // clear beats a same-edge update
            end else if (stage_q.valid) begin
                acc <= acc_nxt;
            end
        end
    end

    // fixed two-cycle latency, one result per strobe
    a_lat_fwd: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> ##2 out_valid
    ) else $error("strobe produced no result");

    a_lat_back: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 2)
    ) else $error("result without a strobe");

    // multiplier tree against plain arithmetic
    a_product: assert property (
        @(posedge clk) disable iff (!rst_n)
        stage_q.valid |->
            stage_q.product == `MAC_PROD_W'($past(a)) * `MAC_PROD_W'($past(b))
    ) else $error("product mismatch");

endmodule

`default_nettype wire

// File: logic/mac_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module mac_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cfg_we,
    input  wire mac_pkg::mac_op_e cfg_op,
    input  wire                   cfg_sat,
    input  wire                   acc_clr,
    input  wire                   in_valid,
    input  wire [`MAC_OPND_W-1:0] a,
    input  wire [`MAC_OPND_W-1:0] b,
    output wire                   out_valid,
    output wire [`MAC_ACC_W-1:0]  acc
);
    import mac_pkg::*;

    mac_cfg_t cfg;  // live opcode and saturation

    mac_ctrl_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_we  (cfg_we),
        .cfg_op  (cfg_op),
        .cfg_sat (cfg_sat),
        .cfg     (cfg)
    );

    mac_datapath u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .acc_clr   (acc_clr),
        .cfg       (cfg),
        .out_valid (out_valid),
        .acc       (acc)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;  // even duty cycle
        end
    end

endmodule

`default_nettype wire

// File: test/tb_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module tb_mac;
    import mac_pkg::*;

    localparam int OPND_W = `MAC_OPND_W;
    localparam int PROD_W = `MAC_PROD_W;
    localparam int ACC_W  = `MAC_ACC_W;
    localparam int IDLE_LIMIT = 20;  // cycles allowed for the pipeline to drain

    typedef struct packed {
        logic [ACC_W-1:0] acc;
        mac_cfg_t         cfg;  // cfg the item was sampled with
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              cfg_we;
    mac_op_e           cfg_op;
    logic              cfg_sat;
    logic              acc_clr;
    logic              in_valid;
    logic [OPND_W-1:0] a;
    logic [OPND_W-1:0] b;
    wire               out_valid;
    wire  [ACC_W-1:0]  acc;

    logic [31:0]       lfsr_state = 32'h3da2;
    string             test_name = "init";
    int                sent_count = 0;
    int                rd_idx = 0;
    expect_t           exp_q[$];

    // reference model state
    mac_cfg_t          m_cfg;
    logic [ACC_W-1:0]  m_acc;
    logic              m_out_valid;
    logic              st_valid;
    logic [PROD_W-1:0] st_prod;
    mac_cfg_t          st_cfg;
    expect_t           new_item;
    expect_t           got_item;
    mac_op_e           got_op;

    tb_clock_gen #(.PERIOD_NS(40.0)) u_clk (.clk(clk));

    mac_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_op    (cfg_op),
        .cfg_sat   (cfg_sat),
        .acc_clr   (acc_clr),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .acc       (acc)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [ACC_W-1:0] model_update(input logic [ACC_W-1:0] acc_in,
                                                      input logic [PROD_W-1:0] prod,
                                                      input mac_cfg_t c);
        logic [ACC_W-1:0] p;
        logic [ACC_W:0]   wide;
        logic [ACC_W-1:0] res;
        p = ACC_W'(prod);
        res = acc_in;
        case (c.op)
            OP_HOLD: res = acc_in;
            OP_LOAD: res = p;
            OP_ADD: begin
                wide = {1'b0, acc_in} + {1'b0, p};
                res = (c.sat_en && wide[ACC_W]) ? '1 : wide[ACC_W-1:0];
            end
            OP_SUB: begin
                if (c.sat_en && (p > acc_in)) begin
                    res = '0;
                end else begin
                    res = acc_in - p;  // wraps mod 2**ACC_W
                end
            end
            default: res = acc_in;
        endcase
        return res;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input string name, input logic [ACC_W-1:0] expected,
                               input logic [ACC_W-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // model runs on the sampled inputs, stage 2 before stage 1 before cfg
    always @(posedge clk) begin
        if (!rst_n) begin
            m_cfg.op     = OP_ADD;
            m_cfg.sat_en = 1'b0;
            m_acc        = '0;
            m_out_valid  = 1'b0;
            st_valid     = 1'b0;
        end else begin
            m_out_valid = st_valid;
            if (acc_clr) begin
                m_acc = '0;
            end else if (st_valid) begin
                m_acc = model_update(m_acc, st_prod, st_cfg);
            end
            if (st_valid) begin
                new_item.acc = m_acc;
                new_item.cfg = st_cfg;
                exp_q.push_back(new_item);
            end
            st_valid = in_valid;
            if (in_valid) begin
                st_prod = PROD_W'(a) * PROD_W'(b);
                st_cfg  = m_cfg;
            end
            if (cfg_we) begin
                m_cfg.op     = cfg_op;
                m_cfg.sat_en = cfg_sat;
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_equal($sformatf("%s out_valid", test_name), ACC_W'(m_out_valid),
                        ACC_W'(out_valid));
        end
        if (rst_n && out_valid) begin
            if (rd_idx >= exp_q.size()) begin
                abort_run("a result came out with no operand strobe behind it");
            end else begin
                got_item = exp_q[rd_idx];
                got_op   = got_item.cfg.op;
                check_equal($sformatf("%s (%s sat=%0d)", test_name, got_op.name(),
                                      got_item.cfg.sat_en), got_item.acc, acc);
                rd_idx++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive(input logic v, input logic [OPND_W-1:0] x, input logic [OPND_W-1:0] y,
                         input logic we, input mac_op_e op, input logic sat, input logic clr);
        next_cycle();
        in_valid = v;
        a        = x;
        b        = y;
        cfg_we   = we;
        cfg_op   = op;
        cfg_sat  = sat;
        acc_clr  = clr;
        if (v) begin
            sent_count++;
        end
    endtask

    task automatic strobe(input logic [OPND_W-1:0] x, input logic [OPND_W-1:0] y);
        drive(1'b1, x, y, 1'b0, OP_HOLD, 1'b0, 1'b0);
    endtask

    task automatic random_strobe();
        logic [OPND_W-1:0] x;
        logic [OPND_W-1:0] y;
        x = OPND_W'(rand_bits(OPND_W));
        y = OPND_W'(rand_bits(OPND_W));
        strobe(x, y);
    endtask

    task automatic write_cfg(input mac_op_e op, input logic sat, input logic clr);
        drive(1'b0, '0, '0, 1'b1, op, sat, clr);
    endtask

    task automatic wait_idle();
        int cycles;
        drive(1'b0, '0, '0, 1'b0, OP_HOLD, 1'b0, 1'b0);
        cycles = 0;
        while ((sent_count != rd_idx) && (cycles < IDLE_LIMIT)) begin
            next_cycle();
            cycles++;
        end
        if (sent_count != rd_idx) begin
            abort_run($sformatf("timeout in %s, no result arrived for a pending strobe",
                                test_name));
        end
    endtask

    task automatic hold_reset();
        rst_n = 1'b0;
        repeat (8) next_cycle();
        rst_n = 1'b1;
    endtask

    initial begin
        rst_n    = 1'b0;
        cfg_we   = 1'b0;
        cfg_op   = OP_HOLD;
        cfg_sat  = 1'b0;
        acc_clr  = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        hold_reset();

        test_name = "multiplier";
        write_cfg(OP_LOAD, 1'b0, 1'b0);
        repeat (200) random_strobe();
        wait_idle();

        test_name = "accumulate_wrap";
        write_cfg(OP_ADD, 1'b0, 1'b1);
        repeat (1500) random_strobe();  // sum runs well past 16 bits
        wait_idle();

        test_name = "subtract_wrap";
        write_cfg(OP_SUB, 1'b0, 1'b1);
        repeat (20) random_strobe();
        wait_idle();

        test_name = "subtract_clamp";
        write_cfg(OP_LOAD, 1'b0, 1'b0);
        strobe(4'd3, 4'd3);
        write_cfg(OP_SUB, 1'b1, 1'b0);
        repeat (20) random_strobe();
        wait_idle();

        test_name = "add_clamp";
        write_cfg(OP_SUB, 1'b0, 1'b1);
        strobe(4'd15, 4'd15);  // preload 16'hff1f
        write_cfg(OP_ADD, 1'b1, 1'b0);
        repeat (20) random_strobe();
        wait_idle();

        test_name = "cfg_timing";
        write_cfg(OP_ADD, 1'b0, 1'b1);
        strobe(4'd5, 4'd7);
        drive(1'b1, 4'd3, 4'd4, 1'b1, OP_LOAD, 1'b0, 1'b0);  // still adds
        strobe(4'd2, 4'd6);
        drive(1'b1, 4'd1, 4'd1, 1'b1, OP_HOLD, 1'b0, 1'b0);  // still loads
        repeat (4) random_strobe();
        wait_idle();

        test_name = "clear";
        write_cfg(OP_ADD, 1'b0, 1'b0);
        strobe(4'd9, 4'd9);
        strobe(4'd8, 4'd8);
        drive(1'b0, '0, '0, 1'b0, OP_HOLD, 1'b0, 1'b1);  // lands on the 8*8 update
        strobe(4'd2, 4'd3);
        drive(1'b1, 4'd4, 4'd4, 1'b0, OP_HOLD, 1'b0, 1'b1);
        wait_idle();

        test_name = "random_mix";
        repeat (300) begin
            drive(1'(rand_bits(1)), OPND_W'(rand_bits(OPND_W)), OPND_W'(rand_bits(OPND_W)),
                  (rand_bits(3) == 0), mac_op_e'(2'(rand_bits(2))), 1'(rand_bits(1)),
                  (rand_bits(4) == 0));
        end
        wait_idle();

        test_name = "reset";
        hold_reset();
        repeat (10) next_cycle();  // any out_valid here has no strobe behind it
        strobe(4'd6, 4'd7);
        wait_idle();

        if (rd_idx != exp_q.size()) begin
            abort_run("results still outstanding at the end of the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/mac_pkg.sv
logic/ks_adder.sv
logic/array_multiplier.sv
logic/mac_ctrl_regs.sv
logic/mac_datapath.sv
logic/mac_top.sv
test/tb_clock_gen.sv
test/tb_mac.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f verilog.f --top-module tb_mac \
    -o tb_mac_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_mac_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
